//--- common/cpuIsaPkg.sv
// Instruction set definitions: opcodes, branch codes, instruction word and flag positions
package cpuIsaPkg;

   typedef enum logic [4:0] {
      ADD    = 5'h00,
      ADDI   = 5'h01,
      ADDIB  = 5'h02,   // Byte immediate, Rd is also the source
      SUB    = 5'h04,
      SUBI   = 5'h05,
      SUBIB  = 5'h06,
      NEG    = 5'h07,
      CMP    = 5'h08,
      CMPI   = 5'h09,
      AND    = 5'h0A,
      OR     = 5'h0B,
      XOR    = 5'h0C,
      NOT    = 5'h0D,
      NAND   = 5'h0E,
      NOR    = 5'h0F,
      LSL    = 5'h10,
      LSR    = 5'h11,
      ASR    = 5'h12,
      LDW    = 5'h14,
      STW    = 5'h15,
      BRANCH = 5'h18    // Condition in the branch code field
   } opcode_t;

   typedef enum logic [2:0] {
      BR  = 3'd0,
      BNE = 3'd1,
      BE  = 3'd2,
      BLT = 3'd3,
      BGE = 3'd4,
      JMP = 3'd7        // Register relative, always taken
   } branchCode_t;

   typedef struct packed {
      opcode_t     Opcode;
      branchCode_t Branch;
   } instrWord_t;

   // Bit positions in the ALU flags word
   localparam int FlagC = 0;
   localparam int FlagV = 1;
   localparam int FlagN = 2;
   localparam int FlagZ = 3;

   typedef logic [3:0] flags_t;

endpackage

//--- common/ctrlSignalsPkg.sv
// Control types: sequencer phase and step, datapath selectors, control and pad strobe structs
package ctrlSignalsPkg;

   typedef enum logic {
      PhFetch,
      PhExecute
   } phase_t;

   typedef enum logic [2:0] {
      StAddr      = 3'd0,   // ALE cycle
      StSelect    = 3'd1,   // nME low, held by the wait counter
      StStrobe    = 3'd2,   // Last nME low cycle, ENB for reads
      StFinish    = 3'd3,   // IR load in fetch, first cycle of execute
      StWriteback = 3'd4    // End of a memory instruction
   } step_t;

   typedef struct packed {
      phase_t Phase;
      step_t  Step;
   } seqState_t;

   typedef enum logic [3:0] {
      FnA, FnADD, FnSUB, FnNEG, FnAND, FnOR, FnXOR,
      FnNOT, FnNAND, FnNOR, FnLSL, FnLSR, FnASR
   } aluFn_t;

   typedef enum logic {Op1Rd1, Op1Pc}    op1Sel_t;
   typedef enum logic {Op2Imm, Op2Rd2}   op2Sel_t;
   typedef enum logic {ImmLong, ImmShort} immSel_t;
   typedef enum logic {Rs1Ra, Rs1Rd}     rs1Sel_t;
   typedef enum logic {WdAlu, WdSys}     wdSel_t;
   typedef enum logic [1:0] {Pc1 = 2'd0, PcAluOut = 2'd1} pcSel_t;

   // Selector zero values are the idle choices
   typedef struct packed {
      aluFn_t  AluOp;
      op1Sel_t Op1Sel;
      op2Sel_t Op2Sel;
      immSel_t ImmSel;
      rs1Sel_t Rs1Sel;
      wdSel_t  WdSel;
      pcSel_t  PcSel;
      logic    AluEn;   // ALU register onto the system bus
      logic    AluWe;
      logic    PcEn;    // PC onto the system bus
      logic    PcWe;
      logic    IrWe;
      logic    RegWe;
   } dpCtrl_t;

   typedef struct packed {
      logic MemEn;
      logic nWE;
      logic nOE;
      logic nME;
      logic ENB;
      logic ALE;
   } memPads_t;

endpackage

//--- logic/statusFlags.sv
// Status register and branch condition evaluation
module statusFlags (
   input  logic                   Clock,
   input  logic                   nReset,
   input  cpuIsaPkg::flags_t      Flags,
   input  logic                   StatusWe,
   input  cpuIsaPkg::branchCode_t Branch,
   output logic                   BranchTaken
);
   import cpuIsaPkg::*;

   flags_t StatusReg;
   logic   SignMismatch;    // N differs from V, signed less than

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         StatusReg <= '0;
      end else if (StatusWe) begin
         StatusReg <= Flags;
      end
   end

   assign SignMismatch = StatusReg[FlagN] ^ StatusReg[FlagV];

   // Conditions use the flags held before this cycle's update
   always_comb begin
      case (Branch)
         BR, JMP: BranchTaken = 1'b1;
         BNE:     BranchTaken = !StatusReg[FlagZ];
         BE:      BranchTaken = StatusReg[FlagZ];
         BLT:     BranchTaken = SignMismatch;
         BGE:     BranchTaken = !SignMismatch;
         default: BranchTaken = 1'b0;
      endcase
   end

   branchKnown: assert property (@(posedge Clock) disable iff (!nReset)
      !$isunknown(BranchTaken));

endmodule

//--- logic/memBusStrobes.sv
// Memory pad strobes from sequencer step and opcode
module memBusStrobes (
   input  ctrlSignalsPkg::seqState_t State,
   input  cpuIsaPkg::opcode_t        Opcode,
   output ctrlSignalsPkg::memPads_t  Pads
);
   import cpuIsaPkg::*;
   import ctrlSignalsPkg::*;

   logic MemCycle;    // Step belongs to a bus access
   logic ReadCycle;

   assign MemCycle  = (State.Phase == PhFetch) || (Opcode inside {LDW, STW});
   assign ReadCycle = (State.Phase == PhFetch) || (Opcode == LDW);

   always_comb begin
      Pads = '{MemEn: 1'b0, nWE: 1'b1, nOE: 1'b1, nME: 1'b1, ENB: 1'b0, ALE: 1'b0};
      if (MemCycle) begin
         case (State.Step)
            StAddr: Pads.ALE = 1'b1;
            StSelect, StStrobe: begin
               Pads.nME   = 1'b0;
               Pads.MemEn = ReadCycle;
               Pads.nOE   = !ReadCycle;                       // Stores keep the output off
               Pads.ENB   = ReadCycle && (State.Step == StStrobe);
            end
            default: ;
         endcase
      end
   end

endmodule

//--- control/phaseSequencer.sv
// Fetch/execute state machine with sub-cycle step and memory wait counter
module phaseSequencer #(
   parameter int MemWaitCycles = 1
) (
   input  logic                      Clock,
   input  logic                      nReset,
   input  cpuIsaPkg::opcode_t        Opcode,
   output ctrlSignalsPkg::seqState_t State
);
   import cpuIsaPkg::*;
   import ctrlSignalsPkg::*;

   localparam int CntW = $clog2(MemWaitCycles + 1);

   logic [CntW-1:0] WaitCnt;    // Select cycles already spent
   logic            WaitDone;
   logic            IsMemOp;

   assign WaitDone = (WaitCnt == CntW'(MemWaitCycles - 1));
   assign IsMemOp  = Opcode inside {LDW, STW};

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         State.Phase <= PhFetch;
         State.Step  <= StAddr;
         WaitCnt     <= '0;
      end else begin
         case (State.Step)
            StAddr: begin
               State.Step <= StSelect;
               WaitCnt    <= '0;
            end
            StSelect: begin
               if (WaitDone) begin
                  State.Step <= StStrobe;           // Strobe is the last nME low cycle
               end else begin
                  WaitCnt <= WaitCnt + 1'b1;
               end
            end
            StStrobe: begin
               State.Step <= (State.Phase == PhFetch) ? StFinish : StWriteback;
            end
            StFinish: begin
               if (State.Phase == PhFetch) begin
                  State.Phase <= PhExecute;         // Execute opens on the finish step
               end else if (IsMemOp) begin
                  State.Step <= StAddr;             // Address is ready, go latch it
               end else begin
                  State.Phase <= PhFetch;
                  State.Step  <= StAddr;
               end
            end
            default: begin                          // Writeback, or an illegal step
               State.Phase <= PhFetch;
               State.Step  <= StAddr;
            end
         endcase
      end
   end

   // Only memory instructions may leave the first execute step
   stepLegal: assert property (@(posedge Clock) disable iff (!nReset)
      (State.Phase == PhFetch) ? (State.Step inside {StAddr, StSelect, StStrobe, StFinish})
                               : (State.Step == StFinish || IsMemOp));

endmodule

//--- control/datapathDecode.sv
// Datapath control decode from opcode and sequencer step, with status write enable
module datapathDecode (
   input  ctrlSignalsPkg::seqState_t State,
   input  cpuIsaPkg::instrWord_t     Instr,
   input  logic                      BranchTaken,
   output ctrlSignalsPkg::dpCtrl_t   DpCtrl,
   output logic                      StatusWe
);
   import cpuIsaPkg::*;
   import ctrlSignalsPkg::*;

   aluFn_t AluFn;
   logic   IsAlu;
   logic   IsCompare;
   logic   Op2Reg;      // Second operand from Rd2
   logic   ImmForm;
   logic   ByteForm;
   logic   IsMemOp;
   logic   IsJmp;

   assign IsCompare = Instr.Opcode inside {CMP, CMPI};
   assign Op2Reg    = Instr.Opcode inside {ADD, SUB, CMP, AND, OR, XOR, NAND, NOR};
   assign ImmForm   = Instr.Opcode inside {ADDI, ADDIB, SUBI, SUBIB, CMPI, LSL, LSR, ASR};
   assign ByteForm  = Instr.Opcode inside {ADDIB, SUBIB};
   assign IsMemOp   = Instr.Opcode inside {LDW, STW};
   assign IsJmp     = (Instr.Branch == JMP);

   always_comb begin
      IsAlu = 1'b1;
      case (Instr.Opcode)
         ADD, ADDI, ADDIB:        AluFn = FnADD;
         SUB, SUBI, SUBIB, CMP, CMPI: AluFn = FnSUB;   // Compare subtracts for the flags
         NEG:                     AluFn = FnNEG;
         AND:                     AluFn = FnAND;
         OR:                      AluFn = FnOR;
         XOR:                     AluFn = FnXOR;
         NOT:                     AluFn = FnNOT;
         NAND:                    AluFn = FnNAND;
         NOR:                     AluFn = FnNOR;
         LSL:                     AluFn = FnLSL;
         LSR:                     AluFn = FnLSR;
         ASR:                     AluFn = FnASR;
         default: begin
            AluFn = FnA;
            IsAlu = 1'b0;
         end
      endcase
   end

   always_comb begin
      DpCtrl   = '0;                               // FnA, Rd1, Imm, long, Ra, Alu, Pc1
      StatusWe = 1'b0;
      if (State.Phase == PhFetch) begin
         DpCtrl.PcEn = (State.Step == StAddr);     // PC drives the fetch address
         DpCtrl.IrWe = (State.Step == StFinish);
      end else begin
         case (State.Step)
            StFinish: begin
               if (IsAlu) begin
                  DpCtrl.AluOp  = AluFn;
                  DpCtrl.Op2Sel = Op2Reg ? Op2Rd2 : Op2Imm;
                  DpCtrl.ImmSel = ImmForm ? ImmShort : ImmLong;
                  DpCtrl.Rs1Sel = ByteForm ? Rs1Rd : Rs1Ra;
                  DpCtrl.RegWe  = !IsCompare;
                  DpCtrl.PcEn   = 1'b1;
                  DpCtrl.PcWe   = 1'b1;
                  StatusWe      = 1'b1;
               end else if (IsMemOp) begin
                  DpCtrl.AluOp  = FnADD;           // Base plus offset into the ALU register
                  DpCtrl.ImmSel = ImmShort;
                  DpCtrl.AluEn  = 1'b1;
                  DpCtrl.AluWe  = 1'b1;
               end else if (Instr.Opcode == BRANCH) begin
                  DpCtrl.AluOp  = FnADD;
                  DpCtrl.Op1Sel = IsJmp ? Op1Rd1 : Op1Pc;
                  DpCtrl.ImmSel = IsJmp ? ImmShort : ImmLong;
                  DpCtrl.PcSel  = BranchTaken ? PcAluOut : Pc1;
                  DpCtrl.PcWe   = 1'b1;
               end else begin
                  DpCtrl.PcEn = 1'b1;              // Unknown opcode just steps the PC
                  DpCtrl.PcWe = 1'b1;
               end
            end
            StAddr: DpCtrl.AluEn = 1'b1;           // Address onto the bus for ALE
            StSelect: begin
               if (Instr.Opcode == STW) begin
                  DpCtrl.AluOp  = FnA;             // Store data passes through the ALU
                  DpCtrl.Rs1Sel = Rs1Rd;
                  DpCtrl.AluWe  = 1'b1;
                  DpCtrl.AluEn  = 1'b1;
               end
            end
            StStrobe: DpCtrl.AluEn = (Instr.Opcode == STW);
            StWriteback: begin
               DpCtrl.PcWe = 1'b1;
               if (Instr.Opcode == LDW) begin
                  DpCtrl.WdSel = WdSys;
                  DpCtrl.RegWe = 1'b1;
               end
            end
            default: ;
         endcase
      end
   end

endmodule

//--- control/controlTop.sv
// Control unit top level: phase sequencer, status flags, datapath decode and pad strobes
module controlTop #(
   parameter int MemWaitCycles = 1   // Select stretch per memory access, 1 to 4
) (
   input  logic                     Clock,
   input  logic                     nReset,
   input  cpuIsaPkg::instrWord_t    Instr,
   input  cpuIsaPkg::flags_t        Flags,    // ALU flags of the current cycle
   output ctrlSignalsPkg::dpCtrl_t  DpCtrl,
   output ctrlSignalsPkg::memPads_t Pads
);
   import ctrlSignalsPkg::*;

   seqState_t State;
   logic      StatusWe;
   logic      BranchTaken;

   phaseSequencer #(
      .MemWaitCycles (MemWaitCycles)
   ) sequencer (
      .Clock  (Clock),
      .nReset (nReset),
      .Opcode (Instr.Opcode),
      .State  (State)
   );

   statusFlags status (
      .Clock       (Clock),
      .nReset      (nReset),
      .Flags       (Flags),
      .StatusWe    (StatusWe),
      .Branch      (Instr.Branch),
      .BranchTaken (BranchTaken)
   );

   datapathDecode decode (
      .State       (State),
      .Instr       (Instr),
      .BranchTaken (BranchTaken),
      .DpCtrl      (DpCtrl),
      .StatusWe    (StatusWe)
   );

   memBusStrobes strobes (
      .State  (State),
      .Opcode (Instr.Opcode),
      .Pads   (Pads)
   );

endmodule

//--- dv/controlModel.svh
// Reference model of phase position, pad strobes, decode tables and status register
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

bit     InFetch;
int     PhasePos;      // Cycle index inside the current phase
flags_t HeldStatus;

function automatic bit isMem(opcode_t op);
   return op inside {LDW, STW};
endfunction

function automatic bit setsStatus(opcode_t op);
   return !isMem(op) && op != BRANCH;
endfunction

function automatic aluFn_t aluFnOf(opcode_t op);
   case (op)
      ADD, ADDI, ADDIB:            return FnADD;
      SUB, SUBI, SUBIB, CMP, CMPI: return FnSUB;
      NEG:                         return FnNEG;
      AND:                         return FnAND;
      OR:                          return FnOR;
      XOR:                         return FnXOR;
      NOT:                         return FnNOT;
      NAND:                        return FnNAND;
      NOR:                         return FnNOR;
      LSL:                         return FnLSL;
      LSR:                         return FnLSR;
      ASR:                         return FnASR;
      default:                     return FnA;
   endcase
endfunction

// Binary register forms read Rd2, immediate and shift forms take the short immediate
function automatic bit usesRd2(opcode_t op);
   return op inside {ADD, SUB, CMP, AND, OR, XOR, NAND, NOR};
endfunction

function automatic bit usesShortImm(opcode_t op);
   return op inside {ADDI, ADDIB, SUBI, SUBIB, CMPI, LSL, LSR, ASR};
endfunction

function automatic bit branchTaken(branchCode_t code);
   case (code)
      BNE:     return !HeldStatus[FlagZ];
      BE:      return HeldStatus[FlagZ];
      BLT:     return HeldStatus[FlagN] != HeldStatus[FlagV];
      BGE:     return HeldStatus[FlagN] == HeldStatus[FlagV];
      default: return 1'b1;                       // BR and JMP
   endcase
endfunction

function automatic memPads_t expectedPads(opcode_t op);
   memPads_t p;
   int       busPos;      // 0 is the ALE cycle of a bus access
   bit       read;
   p = '{MemEn: 1'b0, nWE: 1'b1, nOE: 1'b1, nME: 1'b1, ENB: 1'b0, ALE: 1'b0};
   busPos = InFetch ? PhasePos : PhasePos - 1;   // Memory execute starts with the address add
   read = InFetch || op == LDW;
   if (InFetch || isMem(op)) begin
      if (busPos == 0) begin
         p.ALE = 1'b1;
      end else if (busPos >= 1 && busPos <= W + 1) begin
         p.nME = 1'b0;
         p.MemEn = read;
         p.nOE = !read;
         p.ENB = read && busPos == W + 1;
      end
   end
   return p;
endfunction

task automatic resetModel();
   InFetch = 1'b1;
   PhasePos = 0;
   HeldStatus = '0;
endtask

// Called at the rising edge that ends a cycle
task automatic advanceModel(opcode_t op, flags_t fl);
   if (!InFetch && PhasePos == 0 && setsStatus(op)) begin
      HeldStatus = fl;
   end
   PhasePos++;
   if (InFetch && PhasePos == W + 3) begin
      InFetch = 1'b0;
      PhasePos = 0;
   end else if (!InFetch && PhasePos == (isMem(op) ? W + 4 : 1)) begin
      InFetch = 1'b1;
      PhasePos = 0;
   end
endtask

`endif

//--- dv/controlTb.sv
// Testbench for the control unit: clock, reset, random instruction stream, model checks
module controlTb;
   import cpuIsaPkg::*;
   import ctrlSignalsPkg::*;

   localparam int W          = 1;   // Memory wait cycles
   localparam int KindAlu    = 0;
   localparam int KindBranch = 1;
   localparam int KindMem    = 2;
   localparam int KindAny    = 3;

   logic       Clock;
   logic       nReset;
   instrWord_t Instr;
   flags_t     Flags;
   dpCtrl_t    DpCtrl;
   memPads_t   Pads;

   int Errors;
   int Checks;
   int TestsRun;
   int TestsFailed;
   bit Hung;        // An instruction never reached its IR load
   bit SawIrWe;

   opcode_t     AluOps[$]  = '{ADD, ADDI, ADDIB, SUB, SUBI, SUBIB, NEG, CMP, CMPI, AND,
                               OR, XOR, NOT, NAND, NOR, LSL, LSR, ASR};
   branchCode_t BrCodes[$] = '{BR, BNE, BE, BLT, BGE, JMP};

`include "controlModel.svh"

   controlTop #(
      .MemWaitCycles (W)
   ) dut (
      .Clock  (Clock),
      .nReset (nReset),
      .Instr  (Instr),
      .Flags  (Flags),
      .DpCtrl (DpCtrl),
      .Pads   (Pads)
   );

   always #10 Clock = ~Clock;

   task automatic checkValue(string what, logic [31:0] actual, logic [31:0] expected);
      Checks++;
      if (actual !== expected) begin
         Errors++;
         $display("FAIL %0t: %s is %0h, expected %0h", $time, what, actual, expected);
      end
   endtask

   // Mid-cycle comparison of the DUT outputs with the model
   task automatic checkOutputs();
      opcode_t op;
      string   tag;
      dpCtrl_t expCtrl;
      op = Instr.Opcode;
      tag = $sformatf("op %0h pos %0d fetch %0d:", op, PhasePos, InFetch);
      SawIrWe = DpCtrl.IrWe;
      checkValue({tag, " Pads"}, Pads, expectedPads(op));
      if (InFetch) begin
         expCtrl = '0;
         expCtrl.PcEn = (PhasePos == 0);
         expCtrl.IrWe = (PhasePos == W + 2);
         checkValue({tag, " fetch control"}, DpCtrl, expCtrl);
      end else if (isMem(op)) begin
         checkValue({tag, " AluEn"}, DpCtrl.AluEn, PhasePos <= 1 || (op == STW && PhasePos <= W + 2));
         checkValue({tag, " PcWe"}, DpCtrl.PcWe, PhasePos == W + 3);
         checkValue({tag, " RegWe"}, DpCtrl.RegWe, op == LDW && PhasePos == W + 3);
         checkValue({tag, " WdSel"}, DpCtrl.WdSel,
                    (op == LDW && PhasePos == W + 3) ? WdSys : WdAlu);
         if (PhasePos == 0) begin
            checkValue({tag, " AluWe"}, DpCtrl.AluWe, 1);
         end
      end else if (op == BRANCH) begin
         checkValue({tag, " PcSel"}, DpCtrl.PcSel, branchTaken(Instr.Branch) ? PcAluOut : Pc1);
         checkValue({tag, " Op1Sel"}, DpCtrl.Op1Sel, (Instr.Branch == JMP) ? Op1Rd1 : Op1Pc);
         checkValue({tag, " RegWe"}, DpCtrl.RegWe, 0);
         checkValue({tag, " PcWe"}, DpCtrl.PcWe, 1);
      end else begin
         checkValue({tag, " AluOp"}, DpCtrl.AluOp, aluFnOf(op));
         checkValue({tag, " Op2Sel"}, DpCtrl.Op2Sel, usesRd2(op) ? Op2Rd2 : Op2Imm);
         checkValue({tag, " ImmSel"}, DpCtrl.ImmSel, usesShortImm(op) ? ImmShort : ImmLong);
         checkValue({tag, " Rs1Sel"}, DpCtrl.Rs1Sel, (op inside {ADDIB, SUBIB}) ? Rs1Rd : Rs1Ra);
         checkValue({tag, " RegWe"}, DpCtrl.RegWe, !(op inside {CMP, CMPI}));
         checkValue({tag, " PcSel"}, DpCtrl.PcSel, Pc1);
         checkValue({tag, " IrWe"}, DpCtrl.IrWe, 0);
      end
   endtask

   task automatic stepCycle();
      @(negedge Clock);
      checkOutputs();
      @(posedge Clock);
      advanceModel(Instr.Opcode, Flags);
      #1;
      Flags = flags_t'($urandom);
   endtask

   task automatic runUntilIrLoad(int expectedCycles);
      int cycles;
      cycles = 0;
      SawIrWe = 1'b0;
      while (!SawIrWe && cycles < 20) begin
         stepCycle();
         cycles++;
      end
      if (!SawIrWe) begin
         $display("Instruction %0h never completed: no IR load within 20 cycles", Instr);
         Errors++;
         Hung = 1'b1;
      end else begin
         checkValue($sformatf("cycle count of instruction %0h", Instr), cycles, expectedCycles);
      end
   endtask

   task automatic runInstruction(instrWord_t word);
      Instr = word;                                // New IR value after the IR load edge
      runUntilIrLoad(isMem(word.Opcode) ? 2 * W + 7 : W + 4);
   endtask

   function automatic instrWord_t drawInstr(int kind);
      instrWord_t word;
      int         pick;
      pick = (kind == KindAny) ? $urandom_range(KindMem) : kind;
      word.Branch = BrCodes[$urandom_range(BrCodes.size() - 1)];
      case (pick)
         KindAlu:    word.Opcode = AluOps[$urandom_range(AluOps.size() - 1)];
         KindBranch: word.Opcode = BRANCH;
         default:    word.Opcode = ($urandom_range(1) == 1) ? LDW : STW;
      endcase
      return word;
   endfunction

   task automatic reportTest(string name, int errorsBefore);
      TestsRun++;
      if (Errors != errorsBefore) begin
         TestsFailed++;
      end
      $display("[%s] done, %0d errors", name, Errors - errorsBefore);
   endtask

   task automatic runTest(string name, int kind, int count);
      int errorsBefore;
      errorsBefore = Errors;
      for (int i = 0; i < count && !Hung; i++) begin
         if (kind == KindBranch) begin
            runInstruction(drawInstr(KindAlu));    // Loads the status register first
         end
         if (!Hung) begin
            runInstruction(drawInstr(kind));
         end
      end
      reportTest(name, errorsBefore);
   endtask

   initial begin
      int errorsBefore;
      Clock = 1'b0;
      nReset = 1'b0;
      Instr = '{Opcode: ADD, Branch: BR};
      Flags = '0;
      Errors = 0;
      Checks = 0;
      TestsRun = 0;
      TestsFailed = 0;
      Hung = 1'b0;
      void'($urandom(32'he469));
      resetModel();

      errorsBefore = Errors;
      for (int i = 0; i < 4; i++) begin
         @(negedge Clock);
         checkValue("nME in reset", Pads.nME, 1);
         checkValue("MemEn and ENB in reset", {Pads.MemEn, Pads.ENB}, 0);
         checkValue("write enables in reset",
                    {DpCtrl.IrWe, DpCtrl.RegWe, DpCtrl.PcWe, DpCtrl.AluWe}, 0);
         @(posedge Clock);
      end
      #1;
      nReset = 1'b1;
      #5;
      checkValue("ALE in first cycle after reset", Pads.ALE, 1);
      reportTest("reset", errorsBefore);

      errorsBefore = Errors;
      runUntilIrLoad(W + 3);                       // First fetch has no execute before it
      reportTest("first fetch", errorsBefore);
      if (!Hung) runTest("fetch", KindAny, 30);
      if (!Hung) runTest("alu decode", KindAlu, 200);
      if (!Hung) runTest("branches", KindBranch, 100);
      if (!Hung) runTest("load and store", KindMem, 50);

      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               TestsRun, TestsFailed, Checks, Errors);
      if (Errors == 0 && !Hung) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- cpuControl.f
+incdir+dv
common/cpuIsaPkg.sv
common/ctrlSignalsPkg.sv
logic/statusFlags.sv
logic/memBusStrobes.sv
control/phaseSequencer.sv
control/datapathDecode.sv
control/controlTop.sv
dv/controlTb.sv

//--- Bender.yml
package:
  name: cpuControl

sources:
  - files:
      - common/cpuIsaPkg.sv
      - common/ctrlSignalsPkg.sv
      - logic/statusFlags.sv
      - logic/memBusStrobes.sv
      - control/phaseSequencer.sv
      - control/datapathDecode.sv
      - control/controlTop.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/controlTb.sv
